//--- flist.f
+incdir+logic
logic/glay_pkg.sv
logic/kernel_control.sv
logic/descriptor_decode.sv
logic/vertex_execute.sv
logic/result_stream.sv
logic/glay_kernel_top.sv
verif/glay_kernel_tb.sv

//--- logic/descriptor_decode.sv
// Descriptor to job decode
// One job per rising edge of desc_valid
// Opcode cast and count to length conversion

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module descriptor_decode (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  logic                      desc_valid,
    input  logic [`GLAY_OP_W-1:0]     desc_opcode,
    input  logic [`GLAY_INDEX_W-1:0]  desc_base,
    input  logic [`GLAY_COUNT_W-1:0]  desc_count,
    input  logic [`GLAY_DATA_W-1:0]   desc_value,
    input  logic                      desc_endian,
    input  logic                      job_ready,
    output logic                      job_valid,
    output glay_pkg::vertex_op_e      job_op,
    output logic [`GLAY_INDEX_W-1:0]  job_base,
    output logic [`GLAY_COUNT_W:0]    job_length,
    output logic [`GLAY_DATA_W-1:0]   job_seed,
    output logic                      job_endian
);

    // Set once this valid period has produced its job
    logic desc_taken;
    logic issue;

    // New period, and the job slot is empty
    assign issue = desc_valid && !desc_taken && !job_valid;

    // --------------------
    // Job control
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            desc_taken <= 1'b0;
            job_valid  <= 1'b0;
        end else begin
            // Re-arm when desc_valid drops
            if (!desc_valid) begin
                desc_taken <= 1'b0;
            end else if (issue) begin
                desc_taken <= 1'b1;
            end
            if (issue) begin
                job_valid <= 1'b1;
            end else if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end
        end
    end

    // Job fields, held until the handshake
    always_ff @(posedge ap_clk) begin
        if (issue) begin
            job_op     <= glay_pkg::vertex_op_e'(desc_opcode);
            job_base   <= desc_base;
            job_length <= {1'b0, desc_count} + 1'b1;
            job_seed   <= desc_value;
            job_endian <= desc_endian;
        end
    end

endmodule

`default_nettype wire

//--- logic/glay_config.svh
// Width macros for the graph kernel slice
// Shared by the RTL and the testbench
// Data, index, count and opcode field widths

`ifndef GLAY_CONFIG_SVH
`define GLAY_CONFIG_SVH

// --------------------
// Data path widths
// --------------------

// Seed value and result data
// The endian swap works on its four bytes
`define GLAY_DATA_W 32

// Vertex base and output index
`define GLAY_INDEX_W 32

// --------------------
// Descriptor fields
// --------------------

// Vertex count field, a job runs count plus one vertices
`define GLAY_COUNT_W 8

// Opcode field, matches vertex_op_e
`define GLAY_OP_W 2

`endif

//--- logic/glay_kernel_top.sv
// Top level of the graph kernel slice
// Control, decode, execute and result stream

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module glay_kernel_top (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  logic                      ap_start,
    input  logic [`GLAY_OP_W-1:0]     desc_opcode,
    input  logic [`GLAY_INDEX_W-1:0]  desc_base,
    input  logic [`GLAY_COUNT_W-1:0]  desc_count,
    input  logic [`GLAY_DATA_W-1:0]   desc_value,
    input  logic                      desc_endian,
    input  logic                      m_ready,
    output logic                      ap_ready,
    output logic                      ap_done,
    output logic                      ap_idle,
    output logic                      start,
    output logic                      endian,
    output logic                      m_valid,
    output logic [`GLAY_INDEX_W-1:0]  m_index,
    output logic [`GLAY_DATA_W-1:0]   m_data,
    output logic                      m_last
);

    // Delayed descriptor from control
    logic                     desc_valid;
    logic [`GLAY_OP_W-1:0]    ctrl_opcode;
    logic [`GLAY_INDEX_W-1:0] ctrl_base;
    logic [`GLAY_COUNT_W-1:0] ctrl_count;
    logic [`GLAY_DATA_W-1:0]  ctrl_value;
    logic                     ctrl_endian;

    // Job channel
    logic                     job_valid;
    logic                     job_ready;
    glay_pkg::vertex_op_e     job_op;
    logic [`GLAY_INDEX_W-1:0] job_base;
    logic [`GLAY_COUNT_W:0]   job_length;
    logic [`GLAY_DATA_W-1:0]  job_seed;
    logic                     job_endian;

    // Item channel
    logic                     item_valid;
    logic                     item_ready;
    logic [`GLAY_INDEX_W-1:0] item_index;
    logic [`GLAY_DATA_W-1:0]  item_data;
    logic                     item_last;

    logic                     cu_done;

    // --------------------
    // Control
    // --------------------
    // Free execute stage doubles as cu_setup
    kernel_control u_control (
        .ap_clk          (ap_clk),
        .areset_control  (areset_control),
        .ap_start        (ap_start),
        .cu_setup        (job_ready),
        .cu_done         (cu_done),
        .desc_in_opcode  (desc_opcode),
        .desc_in_base    (desc_base),
        .desc_in_count   (desc_count),
        .desc_in_value   (desc_value),
        .desc_in_endian  (desc_endian),
        .ap_ready        (ap_ready),
        .ap_done         (ap_done),
        .ap_idle         (ap_idle),
        .start           (start),
        .endian          (endian),
        .desc_valid      (desc_valid),
        .desc_out_opcode (ctrl_opcode),
        .desc_out_base   (ctrl_base),
        .desc_out_count  (ctrl_count),
        .desc_out_value  (ctrl_value),
        .desc_out_endian (ctrl_endian)
    );

    // --------------------
    // Compute path
    // --------------------
    descriptor_decode u_decode (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .desc_valid     (desc_valid),
        .desc_opcode    (ctrl_opcode),
        .desc_base      (ctrl_base),
        .desc_count     (ctrl_count),
        .desc_value     (ctrl_value),
        .desc_endian    (ctrl_endian),
        .job_ready      (job_ready),
        .job_valid      (job_valid),
        .job_op         (job_op),
        .job_base       (job_base),
        .job_length     (job_length),
        .job_seed       (job_seed),
        .job_endian     (job_endian)
    );

    vertex_execute u_execute (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .job_valid      (job_valid),
        .job_op         (job_op),
        .job_base       (job_base),
        .job_length     (job_length),
        .job_seed       (job_seed),
        .item_ready     (item_ready),
        .job_ready      (job_ready),
        .item_valid     (item_valid),
        .item_index     (item_index),
        .item_data      (item_data),
        .item_last      (item_last)
    );

    result_stream u_result (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .job_endian     (job_endian),
        .item_valid     (item_valid),
        .item_index     (item_index),
        .item_data      (item_data),
        .item_last      (item_last),
        .m_ready        (m_ready),
        .item_ready     (item_ready),
        .m_valid        (m_valid),
        .m_index        (m_index),
        .m_data         (m_data),
        .m_last         (m_last),
        .cu_done        (cu_done)
    );

endmodule

`default_nettype wire

//--- logic/glay_pkg.sv
// Shared types for the graph kernel slice
// Control state encoding for kernel_control
// Vertex operation encoding for decode and execute

`default_nettype none

`include "glay_config.svh"

package glay_pkg;

    // --------------------
    // Control states
    // --------------------

    // User-managed host sequence
    typedef enum logic [2:0] {
        CTRL_RESET = 3'd0,
        CTRL_IDLE  = 3'd1,
        CTRL_SETUP = 3'd2,
        CTRL_READY = 3'd3,
        CTRL_START = 3'd4,
        CTRL_BUSY  = 3'd5,
        CTRL_DONE  = 3'd6
    } control_state_e;

    // --------------------
    // Vertex operations
    // --------------------

    // i is the vertex offset within the job, all sums wrap at 32 bits
    // Fill gives seed, ramp seed + i, stride seed + 2i
    // Accum starts at seed + base, then adds base + i per vertex
    typedef enum logic [`GLAY_OP_W-1:0] {
        OP_FILL   = 2'd0,
        OP_RAMP   = 2'd1,
        OP_ACCUM  = 2'd2,
        OP_STRIDE = 2'd3
    } vertex_op_e;

endpackage

`default_nettype wire

//--- logic/kernel_control.sv
// User-managed control for the graph kernel
// Level-based ap_start/ap_ready/ap_done/ap_idle handshake
// State-decoded outputs behind a second output register
// Descriptor pass-through in two stages

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module kernel_control (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  logic                      ap_start,
    input  logic                      cu_setup,
    input  logic                      cu_done,
    input  logic [`GLAY_OP_W-1:0]     desc_in_opcode,
    input  logic [`GLAY_INDEX_W-1:0]  desc_in_base,
    input  logic [`GLAY_COUNT_W-1:0]  desc_in_count,
    input  logic [`GLAY_DATA_W-1:0]   desc_in_value,
    input  logic                      desc_in_endian,
    output logic                      ap_ready,
    output logic                      ap_done,
    output logic                      ap_idle,
    output logic                      start,
    output logic                      endian,
    output logic                      desc_valid,
    output logic [`GLAY_OP_W-1:0]     desc_out_opcode,
    output logic [`GLAY_INDEX_W-1:0]  desc_out_base,
    output logic [`GLAY_COUNT_W-1:0]  desc_out_count,
    output logic [`GLAY_DATA_W-1:0]   desc_out_value,
    output logic                      desc_out_endian
);

    // Host start and CU setup, captured once
    logic ap_start_reg;
    logic cu_setup_reg;

    // First output stage, decoded from the state
    logic ap_ready_reg;
    logic ap_done_reg;
    logic ap_idle_reg;
    logic start_reg;
    logic endian_reg;
    logic desc_valid_reg;

    // First descriptor stage
    logic [`GLAY_OP_W-1:0]    desc_opcode_reg;
    logic [`GLAY_INDEX_W-1:0] desc_base_reg;
    logic [`GLAY_COUNT_W-1:0] desc_count_reg;
    logic [`GLAY_DATA_W-1:0]  desc_value_reg;
    logic                     desc_endian_reg;

    glay_pkg::control_state_e current_state;
    glay_pkg::control_state_e next_state;

    // --------------------
    // Input registers
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            // CU comes out of reset free
            cu_setup_reg <= 1'b1;
        end else begin
            ap_start_reg <= ap_start;
            cu_setup_reg <= cu_setup;
        end
    end

    // Descriptor stages, payload only
    always_ff @(posedge ap_clk) begin
        desc_opcode_reg <= desc_in_opcode;
        desc_base_reg   <= desc_in_base;
        desc_count_reg  <= desc_in_count;
        desc_value_reg  <= desc_in_value;
        desc_endian_reg <= desc_in_endian;
        desc_out_opcode <= desc_opcode_reg;
        desc_out_base   <= desc_base_reg;
        desc_out_count  <= desc_count_reg;
        desc_out_value  <= desc_value_reg;
        desc_out_endian <= desc_endian_reg;
    end

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= glay_pkg::CTRL_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            glay_pkg::CTRL_RESET: next_state = glay_pkg::CTRL_IDLE;
            glay_pkg::CTRL_IDLE:  next_state = glay_pkg::CTRL_SETUP;
            // Wait for the host
            glay_pkg::CTRL_SETUP: if (ap_start_reg) next_state = glay_pkg::CTRL_READY;
            // Wait for a free CU
            glay_pkg::CTRL_READY: if (cu_setup_reg) next_state = glay_pkg::CTRL_START;
            glay_pkg::CTRL_START: next_state = glay_pkg::CTRL_BUSY;
            // Raw cu_done keeps ap_done at three cycles
            glay_pkg::CTRL_BUSY:  if (cu_done) next_state = glay_pkg::CTRL_DONE;
            glay_pkg::CTRL_DONE:  if (ap_start_reg) next_state = glay_pkg::CTRL_READY;
            default:              next_state = glay_pkg::CTRL_RESET;
        endcase
    end

    // --------------------
    // Output decode
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready_reg   <= 1'b0;
            ap_done_reg    <= 1'b0;
            ap_idle_reg    <= 1'b1;
            start_reg      <= 1'b0;
            endian_reg     <= 1'b0;
            desc_valid_reg <= 1'b0;
        end else begin
            ap_ready_reg <= (current_state == glay_pkg::CTRL_READY);
            ap_done_reg  <= (current_state == glay_pkg::CTRL_DONE);
            ap_idle_reg  <= (current_state == glay_pkg::CTRL_RESET) ||
                            (current_state == glay_pkg::CTRL_IDLE)  ||
                            (current_state == glay_pkg::CTRL_SETUP) ||
                            (current_state == glay_pkg::CTRL_DONE);
            start_reg    <= (current_state == glay_pkg::CTRL_SETUP) ||
                            (current_state == glay_pkg::CTRL_READY) ||
                            (current_state == glay_pkg::CTRL_START) ||
                            (current_state == glay_pkg::CTRL_BUSY);
            // Descriptor and endian live only in START and BUSY
            desc_valid_reg <= (current_state == glay_pkg::CTRL_START) ||
                              (current_state == glay_pkg::CTRL_BUSY);
            endian_reg     <= desc_endian_reg &&
                              ((current_state == glay_pkg::CTRL_START) ||
                               (current_state == glay_pkg::CTRL_BUSY));
        end
    end

    // Second output stage toward the ports
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready   <= 1'b0;
            ap_done    <= 1'b0;
            ap_idle    <= 1'b1;
            start      <= 1'b0;
            endian     <= 1'b0;
            desc_valid <= 1'b0;
        end else begin
            ap_ready   <= ap_ready_reg;
            ap_done    <= ap_done_reg;
            ap_idle    <= ap_idle_reg;
            start      <= start_reg;
            endian     <= endian_reg;
            desc_valid <= desc_valid_reg;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_stream.sv
// Output register stage for results
// Byte swap on the endian flag, back-pressure from m_ready
// Completion pulse on the last transfer

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module result_stream (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  logic                      job_endian,
    input  logic                      item_valid,
    input  logic [`GLAY_INDEX_W-1:0]  item_index,
    input  logic [`GLAY_DATA_W-1:0]   item_data,
    input  logic                      item_last,
    input  logic                      m_ready,
    output logic                      item_ready,
    output logic                      m_valid,
    output logic [`GLAY_INDEX_W-1:0]  m_index,
    output logic [`GLAY_DATA_W-1:0]   m_data,
    output logic                      m_last,
    output logic                      cu_done
);

    // Byte-reversed item data
    logic [`GLAY_DATA_W-1:0] swapped_data;

    assign swapped_data = {item_data[7:0], item_data[15:8],
                           item_data[23:16], item_data[31:24]};

    // Free when empty or draining this cycle
    assign item_ready = m_ready || !m_valid;

    // Last item leaving the register
    assign cu_done = m_valid && m_ready && m_last;

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            m_valid <= 1'b0;
        end else if (item_valid && item_ready) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // Payload, held while m_ready is low
    always_ff @(posedge ap_clk) begin
        if (item_valid && item_ready) begin
            m_index <= item_index;
            m_data  <= job_endian ? swapped_data : item_data;
            m_last  <= item_last;
        end
    end

endmodule

`default_nettype wire

//--- logic/vertex_execute.sv
// Vertex range walker
// Accepts one job, emits one item per vertex
// Data per vertex from the vertex_op_e rules

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module vertex_execute (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  logic                      job_valid,
    input  glay_pkg::vertex_op_e      job_op,
    input  logic [`GLAY_INDEX_W-1:0]  job_base,
    input  logic [`GLAY_COUNT_W:0]    job_length,
    input  logic [`GLAY_DATA_W-1:0]   job_seed,
    input  logic                      item_ready,
    output logic                      job_ready,
    output logic                      item_valid,
    output logic [`GLAY_INDEX_W-1:0]  item_index,
    output logic [`GLAY_DATA_W-1:0]   item_data,
    output logic                      item_last
);

    // Job in progress
    logic busy;

    // Latched job
    glay_pkg::vertex_op_e     op_reg;
    logic [`GLAY_INDEX_W-1:0] base_reg;
    logic [`GLAY_COUNT_W:0]   length_reg;
    logic [`GLAY_DATA_W-1:0]  seed_reg;

    // Iteration state
    logic [`GLAY_COUNT_W:0]   offset;
    logic [`GLAY_COUNT_W:0]   offset_next;
    logic [`GLAY_DATA_W-1:0]  acc;
    logic [`GLAY_DATA_W-1:0]  base_data;
    logic [`GLAY_DATA_W-1:0]  offset_data;
    logic [`GLAY_DATA_W-1:0]  next_data;
    logic [`GLAY_INDEX_W-1:0] offset_index;

    assign job_ready  = !busy;
    assign item_valid = busy;

    // Zero-extended offsets for the adders
    assign offset_next  = offset + 1'b1;
    assign offset_data  = {{(`GLAY_DATA_W-`GLAY_COUNT_W-1){1'b0}}, offset};
    assign next_data    = {{(`GLAY_DATA_W-`GLAY_COUNT_W-1){1'b0}}, offset_next};
    assign offset_index = {{(`GLAY_INDEX_W-`GLAY_COUNT_W-1){1'b0}}, offset};
    assign base_data    = base_reg;

    // --------------------
    // Item outputs
    // --------------------
    assign item_index = base_reg + offset_index;
    // Final vertex, length is at least one
    assign item_last  = (offset_next == length_reg);

    always_comb begin
        case (op_reg)
            glay_pkg::OP_FILL:   item_data = seed_reg;
            glay_pkg::OP_RAMP:   item_data = seed_reg + offset_data;
            glay_pkg::OP_ACCUM:  item_data = acc;
            glay_pkg::OP_STRIDE: item_data = seed_reg + (offset_data << 1);
            default:             item_data = seed_reg;
        endcase
    end

    // --------------------
    // Job and iteration
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            busy <= 1'b0;
        end else if (job_valid && job_ready) begin
            busy <= 1'b1;
        end else if (item_valid && item_ready && item_last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (job_valid && job_ready) begin
            op_reg     <= job_op;
            base_reg   <= job_base;
            length_reg <= job_length;
            seed_reg   <= job_seed;
            offset     <= '0;
            acc        <= job_seed + job_base;
        end else if (item_valid && item_ready) begin
            // Holds while the result stage stalls
            offset <= offset_next;
            acc    <= acc + base_data + next_data;
        end
    end

endmodule

`default_nettype wire

//--- verif/glay_kernel_tb.sv
// Testbench for glay_kernel_top
// Clock, reset, LFSR stimulus and watchdog
// Reference model of the vertex operations and the endian swap
// Output monitor with back-pressure and run handshake checks

`timescale 1ns/1ps
`default_nettype none

`include "glay_config.svh"

module glay_kernel_tb;

    localparam int RUNS         = 16;
    localparam int MAX_VERTICES = 256;
    // Quarter throughput per vertex plus slack
    localparam int LIMIT_CYCLES = RUNS * MAX_VERTICES * 4 + 200;

    logic                     ap_clk;
    logic                     areset_control;
    logic                     ap_start;
    logic [`GLAY_OP_W-1:0]    desc_opcode;
    logic [`GLAY_INDEX_W-1:0] desc_base;
    logic [`GLAY_COUNT_W-1:0] desc_count;
    logic [`GLAY_DATA_W-1:0]  desc_value;
    logic                     desc_endian;
    logic                     m_ready;
    logic                     ap_ready;
    logic                     ap_done;
    logic                     ap_idle;
    logic                     start;
    logic                     endian;
    logic                     m_valid;
    logic [`GLAY_INDEX_W-1:0] m_index;
    logic [`GLAY_DATA_W-1:0]  m_data;
    logic                     m_last;

    logic [31:0] lfsr_state;
    logic [31:0] ready_bits;
    int          error_count;
    int          failure_count;
    int          check_count;
    int          run_results;
    logic        run_active;
    logic        early_done;
    // Endian flag of the current run
    logic        run_endian;

    // Expected results, in output order
    logic [`GLAY_INDEX_W-1:0] exp_index[$];
    logic [`GLAY_DATA_W-1:0]  exp_data[$];
    logic                     exp_last[$];

    // Output seen stalled at the previous sample
    logic                     stall_seen;
    logic [`GLAY_INDEX_W-1:0] stall_index;
    logic [`GLAY_DATA_W-1:0]  stall_data;
    logic                     stall_last;

    glay_kernel_top UUT (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .ap_start       (ap_start),
        .desc_opcode    (desc_opcode),
        .desc_base      (desc_base),
        .desc_count     (desc_count),
        .desc_value     (desc_value),
        .desc_endian    (desc_endian),
        .m_ready        (m_ready),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .start          (start),
        .endian         (endian),
        .m_valid        (m_valid),
        .m_index        (m_index),
        .m_data         (m_data),
        .m_last         (m_last)
    );

    // --------------------
    // Clock and random bits
    // --------------------
    initial ap_clk = 1'b0;
    always #50 ap_clk = ~ap_clk;

    // Galois step, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int width, output logic [31:0] value);
        int b;
        value = '0;
        for (b = 0; b < width; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[b]   = lfsr_state[0];
        end
    endtask

    // --------------------
    // Checking helpers
    // --------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("%s at %0t", what, $time);
    endtask

    // Reference model of one run
    task automatic build_expected(input logic [31:0] op, input logic [31:0] base,
                                  input logic [31:0] count, input logic [31:0] seed,
                                  input logic swap);
        logic [31:0] acc;
        logic [31:0] value;
        logic [31:0] i;
        acc = seed + base;
        for (i = 0; i <= count; i++) begin
            case (glay_pkg::vertex_op_e'(op[`GLAY_OP_W-1:0]))
                glay_pkg::OP_FILL:   value = seed;
                glay_pkg::OP_RAMP:   value = seed + i;
                glay_pkg::OP_ACCUM: begin
                    // Running sum, first term is seed plus base
                    if (i != 0) begin
                        acc = acc + base + i;
                    end
                    value = acc;
                end
                default:             value = seed + (i << 1);
            endcase
            if (swap) begin
                value = {value[7:0], value[15:8], value[23:16], value[31:24]};
            end
            exp_index.push_back(base + i);
            exp_data.push_back(value);
            exp_last.push_back(i == count);
        end
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(negedge ap_clk) begin
        if (!areset_control) begin
            // Stalled beat must hold
            if (stall_seen) begin
                check_value("m_valid", 32'd1, {31'b0, m_valid});
                check_value("m_index", stall_index, m_index);
                check_value("m_data", stall_data, m_data);
                check_value("m_last", {31'b0, stall_last}, {31'b0, m_last});
            end
            if (m_valid === 1'b1 && m_ready) begin
                if (exp_index.size() == 0) begin
                    report_failure("Output transfer while no result was expected");
                end else begin
                    check_value("m_index", exp_index.pop_front(), m_index);
                    check_value("m_data", exp_data.pop_front(), m_data);
                    check_value("m_last", {31'b0, exp_last.pop_front()}, {31'b0, m_last});
                    // Run's endian flag is forwarded while results flow
                    check_value("endian", {31'b0, run_endian}, {31'b0, endian});
                    run_results++;
                end
            end
            stall_seen  = (m_valid === 1'b1) && !m_ready;
            stall_index = m_index;
            stall_data  = m_data;
            stall_last  = m_last;
            // Done may only follow the final output
            if (run_active && !early_done && ap_done === 1'b1 && exp_index.size() != 0) begin
                early_done = 1'b1;
                report_failure("ap_done went high before the final output");
            end
        end
    end

    // Back-pressure, about three quarters high
    always @(posedge ap_clk) begin
        #1;
        random_bits(2, ready_bits);
        m_ready = (ready_bits[1:0] != 2'b00);
    end

    // --------------------
    // Runs
    // --------------------
    task automatic do_run(input int run);
        logic [31:0] r_op;
        logic [31:0] r_base;
        logic [31:0] r_count;
        logic [31:0] r_value;
        logic [31:0] r_endian;
        logic [31:0] r_hold;
        glay_pkg::vertex_op_e r_kind;
        @(negedge ap_clk);
        random_bits(`GLAY_OP_W, r_op);
        random_bits(`GLAY_INDEX_W, r_base);
        random_bits(`GLAY_COUNT_W, r_count);
        random_bits(`GLAY_DATA_W, r_value);
        random_bits(1, r_endian);
        random_bits(2, r_hold);
        build_expected(r_op, r_base, r_count, r_value, r_endian[0]);
        r_kind = glay_pkg::vertex_op_e'(r_op[`GLAY_OP_W-1:0]);
        $display("Run %0d %s base %h count %0d endian %0d", run,
                 r_kind.name(), r_base, r_count, r_endian[0]);
        @(posedge ap_clk);
        #1;
        desc_opcode = r_op[`GLAY_OP_W-1:0];
        desc_base   = r_base;
        desc_count  = r_count[`GLAY_COUNT_W-1:0];
        desc_value  = r_value;
        desc_endian = r_endian[0];
        run_endian  = r_endian[0];
        ap_start    = 1'b1;
        run_results = 0;
        // Start held until the kernel takes it
        do begin
            @(posedge ap_clk);
            #1;
        end while (ap_ready !== 1'b1);
        ap_start = 1'b0;
        while (ap_done !== 1'b0) begin
            @(posedge ap_clk);
            #1;
        end
        early_done = 1'b0;
        run_active = 1'b1;
        while (ap_done !== 1'b1) begin
            @(posedge ap_clk);
            #1;
        end
        run_active = 1'b0;
        check_value("result_count", r_count + 1, run_results);
        if (exp_index.size() != 0) begin
            report_failure("Run ended with results still missing");
            exp_index.delete();
            exp_data.delete();
            exp_last.delete();
        end
        // Done is a level until the next start
        repeat (r_hold[1:0] + 1) begin
            @(posedge ap_clk);
            #1;
            check_value("ap_done", 32'd1, {31'b0, ap_done});
        end
    endtask

    initial begin
        lfsr_state     = 32'd34;
        error_count    = 0;
        failure_count  = 0;
        check_count    = 0;
        run_results    = 0;
        run_active     = 1'b0;
        early_done     = 1'b0;
        run_endian     = 1'b0;
        stall_seen     = 1'b0;
        areset_control = 1'b1;
        ap_start       = 1'b0;
        desc_opcode    = '0;
        desc_base      = '0;
        desc_count     = '0;
        desc_value     = '0;
        desc_endian    = 1'b0;
        m_ready        = 1'b0;
        repeat (10) @(posedge ap_clk);
        #1;
        areset_control = 1'b0;
        @(negedge ap_clk);
        check_value("ap_idle", 32'd1, {31'b0, ap_idle});
        check_value("ap_ready", 32'd0, {31'b0, ap_ready});
        check_value("ap_done", 32'd0, {31'b0, ap_done});
        check_value("start", 32'd0, {31'b0, start});
        check_value("endian", 32'd0, {31'b0, endian});
        check_value("m_valid", 32'd0, {31'b0, m_valid});
        for (int run = 0; run < RUNS; run++) begin
            do_run(run);
        end
        repeat (5) @(posedge ap_clk);
        $display("Checks %0d, value errors %0d, other failures %0d",
                 check_count, error_count, failure_count);
        if (error_count == 0 && failure_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (LIMIT_CYCLES + 10) @(posedge ap_clk);
        $display("Timeout, the runs did not finish within %0d cycles", LIMIT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
